// File: sources.f
+incdir+common
common/ipod_pkg.sv
common/word_fetch_if.sv
audio/flash_reader.sv
audio/sample_player.sv
speed/speed_control.sv
rtl/sample_rate_gen.sv
rtl/hex_display.sv
rtl/simple_ipod.sv
tb/flash_model.sv
tb/tb_simple_ipod.sv

// File: tb/tb_simple_ipod.sv
`timescale 1ns/100ps
`include "ipod_defines.svh"

module tb_simple_ipod;

  localparam int NUM_WORDS       = 4;
  localparam int REPEAT          = 50;
  localparam int SAMPLE_TIMEOUT  = 2 * 5000 + 100;
  localparam int DISPLAY_TIMEOUT = 20;

  logic        CLK_50M;
  logic        arst_n;
  logic [2:0]  key;
  logic        flash_read;
  logic [22:0] flash_address;
  logic        flash_waitrequest;
  logic [31:0] flash_readdata;
  logic        flash_readdatavalid;
  logic [7:0]  audio_data;
  logic        sample_valid;
  logic [6:0]  hex0;
  logic [6:0]  hex1;
  logic [6:0]  hex2;
  logic [6:0]  hex3;
  logic [6:0]  hex4;
  logic [6:0]  hex5;

  int value_errors   = 0;
  int timeout_errors = 0;
  int bytes_seen     = 0;
  int reads_seen     = 0;

  simple_ipod #(.LAST_ADDR(23'd3), .REPEAT_CYCLES(REPEAT)) DUT
  (
    .CLK_50M             (CLK_50M),
    .arst_n              (arst_n),
    .key                 (key),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_data          (audio_data),
    .sample_valid        (sample_valid),
    .hex0                (hex0),
    .hex1                (hex1),
    .hex2                (hex2),
    .hex3                (hex3),
    .hex4                (hex4),
    .hex5                (hex5)
  );

  flash_model u_flash
  (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .read          (flash_read),
    .address       (flash_address),
    .waitrequest   (flash_waitrequest),
    .readdata      (flash_readdata),
    .readdatavalid (flash_readdatavalid)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ==================================================
  // Expected values
  // ==================================================

  // Active low, a in bit 0 through g in bit 6
  function automatic logic [6:0] seg_pattern(input logic [3:0] nibble);
    case (nibble)
      4'h0: seg_pattern = 7'b1000000;
      4'h1: seg_pattern = 7'b1111001;
      4'h2: seg_pattern = 7'b0100100;
      4'h3: seg_pattern = 7'b0110000;
      4'h4: seg_pattern = 7'b0011001;
      4'h5: seg_pattern = 7'b0010010;
      4'h6: seg_pattern = 7'b0000010;
      4'h7: seg_pattern = 7'b1111000;
      4'h8: seg_pattern = 7'b0000000;
      4'h9: seg_pattern = 7'b0010000;
      4'hA: seg_pattern = 7'b0001000;
      4'hB: seg_pattern = 7'b0000011;
      4'hC: seg_pattern = 7'b1000110;
      4'hD: seg_pattern = 7'b0100001;
      4'hE: seg_pattern = 7'b0000110;
      default: seg_pattern = 7'b0001110;
    endcase
  endfunction

  function automatic logic [41:0] display_pattern(input logic [23:0] value);
    logic [41:0] pat;
    for (int i = 0; i < 6; i++)
      pat[i*7 +: 7] = seg_pattern(value[i*4 +: 4]);
    display_pattern = pat;
  endfunction

  // Upper byte of the first sample, then of the second
  function automatic logic [7:0] expected_byte(input int idx);
    int word_n;
    word_n = (idx / 2) % NUM_WORDS;
    if (idx % 2 == 0)
      expected_byte = 8'hA0 + word_n[7:0];
    else
      expected_byte = 8'h50 + word_n[7:0];
  endfunction

  // ==================================================
  // Helpers
  // ==================================================
  task automatic report_mismatch(input string test_name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("[ERROR] %s: expected %0h, actual %0h", test_name, expected, actual);
    value_errors++;
  endtask

  task automatic check_display(input string test_name, input logic [23:0] period);
    if ({hex5, hex4, hex3, hex2, hex1, hex0} !== display_pattern(period))
      report_mismatch(test_name, display_pattern(period), {hex5, hex4, hex3, hex2, hex1, hex0});
  endtask

  task automatic wait_display(input string test_name, input logic [23:0] period);
    int n;
    n = 0;
    while (({hex5, hex4, hex3, hex2, hex1, hex0} !== display_pattern(period))
           && n < DISPLAY_TIMEOUT)
    begin
      @(negedge CLK_50M);
      n++;
    end
    check_display(test_name, period);
  endtask

  task automatic wait_sample(input string test_name, output logic [7:0] value,
                             output int cycles, output bit ok);
    int n;
    n = 0;
    ok = 1'b0;
    while (!ok && n < SAMPLE_TIMEOUT)
    begin
      @(negedge CLK_50M);
      n++;
      if (sample_valid)
        ok = 1'b1;
    end
    cycles = n;
    value = audio_data;
    if (ok)
      bytes_seen++;
    else
    begin
      $display("%s: no sample_valid pulse within %0d cycles", test_name, SAMPLE_TIMEOUT);
      timeout_errors++;
    end
  endtask

  task automatic press_key(input int idx, input int hold_cycles);
    @(negedge CLK_50M);
    key[idx] = 1'b0;
    repeat (hold_cycles) @(negedge CLK_50M);
    key[idx] = 1'b1;
  endtask

  // Accepted reads walk the song words in order and wrap
  always @(posedge CLK_50M)
  begin
    if (arst_n && flash_read && !flash_waitrequest)
    begin
      if (flash_address !== 23'(reads_seen % NUM_WORDS))
        report_mismatch("flash_address", reads_seen % NUM_WORDS, flash_address);
      reads_seen++;
    end
  end

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic test_reset();
    if (flash_read !== 1'b0)
      report_mismatch("test_reset flash_read", 0, flash_read);
    if (sample_valid !== 1'b0)
      report_mismatch("test_reset sample_valid", 0, sample_valid);
    if (audio_data !== 8'h00)
      report_mismatch("test_reset audio_data", 0, audio_data);
    check_display("test_reset display", 24'h0008E1);
  endtask

  task automatic read_bytes(input string test_name, input int count);
    logic [7:0] value;
    int         cycles;
    bit         ok;
    for (int i = 0; i < count; i++)
    begin
      wait_sample(test_name, value, cycles, ok);
      if (ok && value !== expected_byte(bytes_seen - 1))
        report_mismatch(test_name, expected_byte(bytes_seen - 1), value);
    end
  endtask

  task automatic test_playback_order();
    read_bytes("test_playback_order", 8);
  endtask

  // Word 3 is the last, so word 0 comes back
  task automatic test_wrap();
    read_bytes("test_wrap", 2);
  endtask

  task automatic test_sample_spacing();
    logic [7:0] value;
    int         cycles;
    bit         ok;
    wait_sample("test_sample_spacing", value, cycles, ok);
    for (int i = 0; i < 2; i++)
    begin
      wait_sample("test_sample_spacing", value, cycles, ok);
      if (ok && cycles != `DEFAULT_PERIOD)
        report_mismatch("test_sample_spacing default", `DEFAULT_PERIOD, cycles);
    end
    press_key(0, 5);
    wait_display("test_sample_spacing key", `DEFAULT_PERIOD - `SPEED_STEP);
    repeat (3) @(negedge CLK_50M);
    // Interval in flight still runs on the old period
    wait_sample("test_sample_spacing", value, cycles, ok);
    wait_sample("test_sample_spacing", value, cycles, ok);
    if (ok && cycles != `DEFAULT_PERIOD - `SPEED_STEP)
      report_mismatch("test_sample_spacing faster", `DEFAULT_PERIOD - `SPEED_STEP, cycles);
    press_key(2, 5);
    wait_display("test_sample_spacing restore", `DEFAULT_PERIOD);
  endtask

  task automatic test_speed_keys();
    press_key(0, 5);
    wait_display("test_speed_keys up", 24'd2173);
    press_key(1, 5);
    repeat (10) @(negedge CLK_50M);
    press_key(1, 5);
    wait_display("test_speed_keys down", 24'd2373);
    press_key(2, 5);
    wait_display("test_speed_keys reset", 24'd2273);
    // Sixteen repeat intervals, well past the lower clamp
    press_key(0, 16 * REPEAT);
    wait_display("test_speed_keys clamp", `MIN_PERIOD);
  endtask

  initial
  begin
    arst_n = 1'b0;
    key    = 3'b111;
    repeat (10) @(negedge CLK_50M);
    test_reset();
    arst_n = 1'b1;
    test_playback_order();
    test_wrap();
    test_sample_spacing();
    test_speed_keys();
    $display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: tb/flash_model.sv
`timescale 1ns/100ps

module flash_model
(
  input  logic        CLK_50M,
  input  logic        arst_n,
  input  logic        read,
  input  logic [22:0] address,
  output logic        waitrequest,
  output logic [31:0] readdata,
  output logic        readdatavalid
);

  localparam int P_IDLE  = 0;
  localparam int P_STALL = 1;
  localparam int P_DATA  = 2;

  logic        wait_q     = 1'b0;
  logic        valid_q    = 1'b0;
  logic [31:0] data_q     = '0;
  logic [22:0] addr_q     = '0;
  logic [31:0] lcg_state  = 32'h7978;
  int          phase      = P_IDLE;
  int          stall_left = 0;
  int          latency    = 0;

  assign waitrequest   = wait_q;
  assign readdata      = data_q;
  assign readdatavalid = valid_q;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    lcg_next = s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Word n holds A0+n and 50+n in the upper sample bytes
  function automatic logic [31:0] word_at(input logic [22:0] a);
    logic [7:0] n;
    n = a[7:0] ^ a[15:8] ^ {1'b0, a[22:16]};
    word_at = {8'hA0 + n, 8'h00, 8'h50 + n, 8'h00};
  endfunction

  // Accept the read on the next rising edge, pick the data latency
  task automatic accept_read();
    wait_q    = 1'b0;
    addr_q    = address;
    lcg_state = lcg_next(lcg_state);
    latency   = 1 + lcg_state[16];
    phase     = P_DATA;
  endtask

  // Outputs change on the falling edge only
  always @(negedge CLK_50M)
  begin
    if (!arst_n)
    begin
      phase   = P_IDLE;
      wait_q  = 1'b0;
      valid_q = 1'b0;
    end
    else
    begin
      valid_q = 1'b0;
      case (phase)
        P_IDLE:
        begin
          if (read)
          begin
            lcg_state  = lcg_next(lcg_state);
            stall_left = lcg_state[17:16];
            if (stall_left == 0)
              accept_read();
            else
            begin
              wait_q = 1'b1;
              phase  = P_STALL;
            end
          end
        end
        P_STALL:
        begin
          stall_left = stall_left - 1;
          if (stall_left == 0)
            accept_read();
        end
        default:
        begin
          latency = latency - 1;
          if (latency == 0)
          begin
            data_q  = word_at(addr_q);
            valid_q = 1'b1;
            phase   = P_IDLE;
          end
        end
      endcase
    end
  end

endmodule

// File: rtl/simple_ipod.sv
`timescale 1ns/100ps
`include "ipod_defines.svh"

module simple_ipod import ipod_pkg::*;
#(
  parameter flash_addr_t LAST_ADDR     = `LAST_ADDR,
  parameter int          REPEAT_CYCLES = `REPEAT_CYCLES
)
(
  input  logic        CLK_50M,
  input  logic        arst_n,
  input  logic [2:0]  key,
  // Flash read bus
  output logic        flash_read,
  output flash_addr_t flash_address,
  input  logic        flash_waitrequest,
  input  flash_word_t flash_readdata,
  input  logic        flash_readdatavalid,
  // Audio out
  output sample_t     audio_data,
  output logic        sample_valid,
  // Period display
  output logic [6:0]  hex0,
  output logic [6:0]  hex1,
  output logic [6:0]  hex2,
  output logic [6:0]  hex3,
  output logic [6:0]  hex4,
  output logic [6:0]  hex5
);

  period_t period;
  logic    tick;

  word_fetch_if fetch_bus ();

  // ==================================================
  // Audio path
  // ==================================================
  flash_reader u_flash_reader
  (
    .CLK_50M             (CLK_50M),
    .arst_n              (arst_n),
    .fetch               (fetch_bus.reader),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  sample_player #(.LAST_ADDR(LAST_ADDR)) u_sample_player
  (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .fetch        (fetch_bus.player),
    .tick         (tick),
    .audio_data   (audio_data),
    .sample_valid (sample_valid)
  );

  sample_rate_gen u_sample_rate_gen
  (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .period  (period),
    .tick    (tick)
  );

  // ==================================================
  // Speed keys and display
  // ==================================================
  speed_control #(.REPEAT_CYCLES(REPEAT_CYCLES)) u_speed_control
  (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .key     (key),
    .period  (period)
  );

  hex_display u_hex_display
  (
    .period (period),
    .hex0   (hex0),
    .hex1   (hex1),
    .hex2   (hex2),
    .hex3   (hex3),
    .hex4   (hex4),
    .hex5   (hex5)
  );

endmodule

// File: rtl/hex_display.sv
`timescale 1ns/100ps

module hex_display import ipod_pkg::*;
(
  input  period_t    period,
  output logic [6:0] hex0,
  output logic [6:0] hex1,
  output logic [6:0] hex2,
  output logic [6:0] hex3,
  output logic [6:0] hex4,
  output logic [6:0] hex5
);

  // Active low, segment a in bit 0 up to g in bit 6
  function automatic logic [6:0] seg7(input logic [3:0] nibble);
    case (nibble)
      4'h0: seg7 = 7'h40;
      4'h1: seg7 = 7'h79;
      4'h2: seg7 = 7'h24;
      4'h3: seg7 = 7'h30;
      4'h4: seg7 = 7'h19;
      4'h5: seg7 = 7'h12;
      4'h6: seg7 = 7'h02;
      4'h7: seg7 = 7'h78;
      4'h8: seg7 = 7'h00;
      4'h9: seg7 = 7'h10;
      4'hA: seg7 = 7'h08;
      4'hB: seg7 = 7'h03;
      4'hC: seg7 = 7'h46;
      4'hD: seg7 = 7'h21;
      4'hE: seg7 = 7'h06;
      default: seg7 = 7'h0E;
    endcase
  endfunction

  // Lowest nibble on hex0
  assign hex0 = seg7(period[3:0]);
  assign hex1 = seg7(period[7:4]);
  assign hex2 = seg7(period[11:8]);
  assign hex3 = seg7(period[15:12]);
  assign hex4 = seg7(period[19:16]);
  assign hex5 = seg7(period[23:20]);

endmodule

// File: rtl/sample_rate_gen.sv
`timescale 1ns/100ps
`include "ipod_defines.svh"

module sample_rate_gen import ipod_pkg::*;
(
  input  logic    CLK_50M,
  input  logic    arst_n,
  input  period_t period,
  output logic    tick
);

  period_t count;

  // Down-counter, reload picks up a new period only at wrap
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      count <= `DEFAULT_PERIOD - 24'd1;
      tick  <= 1'b0;
    end
    else if (count == '0)
    begin
      count <= period - 24'd1;
      tick  <= 1'b1;
    end
    else
    begin
      count <= count - 24'd1;
      tick  <= 1'b0;
    end
  end

  // Speed control must never hand over a too-short period
  a_min_period: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    period >= `MIN_PERIOD);

endmodule

// File: speed/speed_control.sv
`timescale 1ns/100ps
`include "ipod_defines.svh"

module speed_control import ipod_pkg::*;
#(
  parameter int REPEAT_CYCLES = `REPEAT_CYCLES
)
(
  input  logic       CLK_50M,
  input  logic       arst_n,
  input  logic [2:0] key,
  output period_t    period
);

  localparam int CNT_W = $clog2(REPEAT_CYCLES + 1);

  logic [2:0]       key_meta;
  logic [2:0]       key_sync;
  logic [CNT_W-1:0] rep_cnt;
  speed_cmd_e       cmd;
  speed_cmd_e       prev_cmd;
  logic             step;

  // Keys are active low, stored active high after sync
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      key_meta <= ~key;
      key_sync <= key_meta;
    end
  end

  // Reset wins, then up, then down
  always_comb
  begin
    if (key_sync[2])
      cmd = CMD_RESET;
    else if (key_sync[0])
      cmd = CMD_UP;
    else if (key_sync[1])
      cmd = CMD_DOWN;
    else
      cmd = CMD_NONE;
  end

  // First press steps at once, a held key steps again per interval
  assign step = (cmd != CMD_NONE) &&
                ((cmd != prev_cmd) || (rep_cnt == CNT_W'(REPEAT_CYCLES - 1)));

  // ==================================================
  // Hold counter and period register
  // ==================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      prev_cmd <= CMD_NONE;
      rep_cnt  <= '0;
      period   <= `DEFAULT_PERIOD;
    end
    else
    begin
      prev_cmd <= cmd;
      if (step || cmd == CMD_NONE)
        rep_cnt <= '0;
      else
        rep_cnt <= rep_cnt + 1'b1;
      if (step)
      begin
        case (cmd)
          // Shorter period plays faster
          CMD_UP:
            period <= (period < `MIN_PERIOD + `SPEED_STEP) ? `MIN_PERIOD
                                                           : period - `SPEED_STEP;
          CMD_DOWN:
            period <= (period > `MAX_PERIOD - `SPEED_STEP) ? `MAX_PERIOD
                                                           : period + `SPEED_STEP;
          CMD_RESET:
            period <= `DEFAULT_PERIOD;
          default:
            period <= period;
        endcase
      end
    end
  end

  a_period_bounds: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    (period >= `MIN_PERIOD) && (period <= `MAX_PERIOD));

endmodule

// File: audio/sample_player.sv
`timescale 1ns/100ps
`include "ipod_defines.svh"

module sample_player import ipod_pkg::*;
#(
  parameter flash_addr_t LAST_ADDR = `LAST_ADDR
)
(
  input  logic         CLK_50M,
  input  logic         arst_n,
  word_fetch_if.player fetch,
  input  logic         tick,
  output sample_t      audio_data,
  output logic         sample_valid
);

  flash_addr_t addr_q;
  flash_word_t word_q;
  logic        req_q;
  logic        booted;
  logic        have_word;
  logic        half;
  logic        pending;

  assign fetch.req  = req_q;
  assign fetch.addr = addr_q;

  // ==================================================
  // Byte sequencing and word requests
  // ==================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      booted       <= 1'b0;
      req_q        <= 1'b0;
      addr_q       <= '0;
      have_word    <= 1'b0;
      half         <= 1'b0;
      pending      <= 1'b0;
      audio_data   <= '0;
      sample_valid <= 1'b0;
    end
    else
    begin
      req_q        <= 1'b0;
      sample_valid <= 1'b0;
      if (fetch.req)
        pending <= 1'b1;
      // Kick off the first word
      if (!booted)
      begin
        booted <= 1'b1;
        req_q  <= 1'b1;
      end
      if (fetch.valid)
      begin
        have_word <= 1'b1;
        pending   <= 1'b0;
      end
      // No word held on a tick means underrun, output holds
      if (tick && have_word)
      begin
        sample_valid <= 1'b1;
        if (!half)
        begin
          audio_data <= sample_t'(word_q[31:24]);
          half       <= 1'b1;
        end
        else
        begin
          audio_data <= sample_t'(word_q[15:8]);
          half       <= 1'b0;
          have_word  <= 1'b0;
          req_q      <= 1'b1;
          addr_q     <= (addr_q == LAST_ADDR) ? '0 : addr_q + 23'd1;
        end
      end
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (fetch.valid)
      word_q <= fetch.word;
  end

  // One request at a time, and each answered once
  a_no_overlap: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    fetch.req |-> !pending);
  a_valid_expected: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    fetch.valid |-> pending);

endmodule

// File: audio/flash_reader.sv
`timescale 1ns/100ps

module flash_reader import ipod_pkg::*;
(
  input  logic        CLK_50M,
  input  logic        arst_n,
  word_fetch_if.reader fetch,
  output logic        flash_read,
  output flash_addr_t flash_address,
  input  logic        flash_waitrequest,
  input  flash_word_t flash_readdata,
  input  logic        flash_readdatavalid
);

  flash_state_e state;
  flash_word_t  word_q;
  logic         valid_q;

  assign fetch.word  = word_q;
  assign fetch.valid = valid_q;

  // ==================================================
  // Read FSM, one word in flight
  // ==================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state      <= IDLE;
      flash_read <= 1'b0;
      valid_q    <= 1'b0;
    end
    else
    begin
      valid_q <= 1'b0;
      case (state)
        IDLE:
        begin
          if (fetch.req)
          begin
            flash_read <= 1'b1;
            state      <= READ;
          end
        end
        READ:
        begin
          // Hold the read until the slave stops stalling
          if (!flash_waitrequest)
          begin
            flash_read <= 1'b0;
            state      <= WAIT_DATA;
          end
        end
        WAIT_DATA:
        begin
          if (flash_readdatavalid)
          begin
            valid_q <= 1'b1;
            state   <= IDLE;
          end
        end
        default:
        begin
          flash_read <= 1'b0;
          state      <= IDLE;
        end
      endcase
    end
  end

  // Address and returned word
  always_ff @(posedge CLK_50M)
  begin
    if (state == IDLE && fetch.req)
      flash_address <= fetch.addr;
    if (state == WAIT_DATA && flash_readdatavalid)
      word_q <= flash_readdata;
  end

  // Avalon rule: a stalled read keeps its command
  a_stall_stable: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    (flash_read && flash_waitrequest) |=> (flash_read && $stable(flash_address)));

endmodule

// File: common/word_fetch_if.sv
`timescale 1ns/100ps

interface word_fetch_if import ipod_pkg::*; ();

  // Request side, from the sample player
  logic        req;
  flash_addr_t addr;

  // Response side, from the flash reader
  flash_word_t word;
  logic        valid;

  modport player
  (
    output req,
    output addr,
    input  word,
    input  valid
  );

  modport reader
  (
    input  req,
    input  addr,
    output word,
    output valid
  );

endinterface

// File: common/ipod_pkg.sv
package ipod_pkg;

  // Flash word address and data
  typedef logic [22:0] flash_addr_t;
  typedef logic [31:0] flash_word_t;

  // Upper byte of a signed 16-bit sample
  typedef logic signed [7:0] sample_t;

  // Clocks per sample tick
  typedef logic [23:0] period_t;

  // Flash read master states
  typedef enum logic [1:0]
  {
    IDLE,
    READ,
    WAIT_DATA
  } flash_state_e;

  // Speed key commands
  typedef enum logic [1:0]
  {
    CMD_NONE,
    CMD_UP,
    CMD_DOWN,
    CMD_RESET
  } speed_cmd_e;

endpackage

// File: common/ipod_defines.svh
`ifndef IPOD_DEFINES_SVH
`define IPOD_DEFINES_SVH

// ==================================================
// Sample rate and speed control
// ==================================================

// About 22 kHz from the 50 MHz clock
`define DEFAULT_PERIOD 24'd2273

// Period change per key step
`define SPEED_STEP 24'd100

// Period limits
`define MIN_PERIOD 24'd1000
`define MAX_PERIOD 24'd5000

// Held-key repeat interval, 100 ms
`define REPEAT_CYCLES 5000000

// Last word address of the song
`define LAST_ADDR 23'h7FFFF

`endif
